// File: rtl/cpuPkg.sv
package cpuPkg;

    typedef logic [31:0] wordT;
    typedef logic [4:0] regIndexT;

    // Primary opcode field
    typedef enum logic [5:0] {
        opSpecial = 6'h00,
        opBeq     = 6'h04,
        opBne     = 6'h05,
        opAddiu   = 6'h09,
        opOri     = 6'h0d,
        opLui     = 6'h0f,
        opLw      = 6'h23,
        opSw      = 6'h2b
    } opcodeE;

    // Function field of SPECIAL
    typedef enum logic [5:0] {
        fnAddu = 6'h21,
        fnSubu = 6'h23,
        fnAnd  = 6'h24,
        fnOr   = 6'h25,
        fnSlt  = 6'h2a
    } functE;

    typedef enum logic [2:0] {aluAdd, aluSub, aluAnd, aluOr, aluSlt, aluLui} aluOpE;

    // Ordered, a higher level freezes every earlier stage
    typedef enum logic [1:0] {stallNone, stallDecode, stallExecute, stallMemory} stallLevelE;

endpackage

// File: rtl/apbPkg.sv
package apbPkg;

    typedef enum logic [1:0] {
        phaseIdle,
        phaseSetup,
        phaseAccess
    } apbPhaseE;

    // Owner of the transfer on the bus
    typedef enum logic {reqFetch, reqData} requesterE;

endpackage

// File: rtl/fetchUnit.sv
module fetchUnit import cpuPkg::*; #(
    parameter wordT resetVector = '0
) (
    input  logic clk,
    input  logic reset,
    input  logic hold,
    input  logic redirect,
    input  wordT redirectAddr,
    output logic fetchReq,
    output wordT fetchAddr,
    input  logic fetchDone,
    input  wordT rdata,
    output wordT instr,
    output wordT instrPc,
    output logic instrValid
);
    wordT pc;
    wordT heldInstr;
    wordT heldPc;
    logic heldValid;
    logic pendingRedirect;
    wordT pendingAddr;

    // No new request while a word waits for decode
    assign fetchReq = !heldValid;
    assign fetchAddr = pc;
    assign instr = heldValid ? heldInstr : rdata;
    assign instrPc = heldValid ? heldPc : pc;
    assign instrValid = heldValid || fetchDone;

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= resetVector;
            heldValid <= 1'b0;
            pendingRedirect <= 1'b0;
        end else if (fetchDone) begin
            // The word just fetched is the delay slot when a redirect is known
            if (redirect) begin
                pc <= redirectAddr;
            end else if (pendingRedirect) begin
                pc <= pendingAddr;
            end else begin
                pc <= pc + 32'd4;
            end
            pendingRedirect <= 1'b0;
            heldValid <= hold;
        end else if (heldValid) begin
            // Delay slot already in hand
            if (redirect) begin
                pc <= redirectAddr;
            end
            if (!hold) begin
                heldValid <= 1'b0;
            end
        end else if (redirect) begin
            pendingRedirect <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (fetchDone && hold) begin
            heldInstr <= rdata;
            heldPc <= pc;
        end
        if (redirect) begin
            pendingAddr <= redirectAddr;
        end
    end

endmodule

// File: rtl/decodeStage.sv
module decodeStage import cpuPkg::*; (
    input  logic     clk,
    input  logic     reset,
    input  logic     hold,
    input  wordT     instr,
    input  wordT     instrPc,
    input  logic     instrValid,
    input  regIndexT exDest,
    input  regIndexT memDest,
    input  wordT     memValue,
    input  logic     memValueValid,
    input  regIndexT wbDest,
    input  wordT     wbValue,
    output logic     decodeWait,
    output logic     redirect,
    output wordT     redirectAddr,
    output aluOpE    dxAluOp,
    output wordT     dxA,
    output wordT     dxB,
    output regIndexT dxDest,
    output logic     dxLoad,
    output logic     dxStore,
    output wordT     dxStoreData,
    output wordT     dxPc
);
    logic decValid;
    wordT decInstr;
    wordT decPc;
    wordT regFile [32];

    opcodeE opcode;
    functE funct;
    regIndexT rs;
    regIndexT rt;
    regIndexT dest;
    aluOpE aluOp;
    logic useRt;
    logic useImm;
    logic zeroExt;
    logic isLoad;
    logic isStore;
    logic isBranch;
    logic issue;
    wordT imm;
    wordT rsValue;
    wordT rtValue;

    // Newest producer wins
    function automatic wordT forward(regIndexT idx, wordT fileValue);
        wordT value;
        value = fileValue;
        if (idx == '0) begin
            value = '0;
        end else if (idx == memDest) begin
            value = memValue;
        end else if (idx == wbDest) begin
            value = wbValue;
        end
        return value;
    endfunction

    function automatic logic conflicts(regIndexT idx);
        return idx != '0 && (idx == exDest || (idx == memDest && !memValueValid));
    endfunction

    always_ff @(posedge clk) begin
        if (reset) begin
            decValid <= 1'b0;
        end else if (!hold) begin
            decValid <= instrValid;
        end
    end

    always_ff @(posedge clk) begin
        if (!hold) begin
            decInstr <= instr;
            decPc <= instrPc;
        end
        if (wbDest != '0) begin
            regFile[wbDest] <= wbValue;
        end
    end

    assign opcode = opcodeE'(decInstr[31:26]);
    assign funct = functE'(decInstr[5:0]);
    assign rs = decInstr[25:21];
    assign rt = decInstr[20:16];

    always_comb begin
        dest = '0;
        aluOp = aluAdd;
        useRt = 1'b0;
        useImm = 1'b1;
        zeroExt = 1'b0;
        isLoad = 1'b0;
        isStore = 1'b0;
        isBranch = 1'b0;
        case (opcode)
            opSpecial: begin
                useRt = 1'b1;
                useImm = 1'b0;
                dest = decInstr[15:11];
                case (funct)
                    fnAddu: aluOp = aluAdd;
                    fnSubu: aluOp = aluSub;
                    fnAnd: aluOp = aluAnd;
                    fnOr: aluOp = aluOr;
                    fnSlt: aluOp = aluSlt;
                    default: dest = '0;
                endcase
            end
            opAddiu: dest = rt;
            opOri: begin
                dest = rt;
                aluOp = aluOr;
                zeroExt = 1'b1;
            end
            opLui: begin
                dest = rt;
                aluOp = aluLui;
            end
            opLw: begin
                dest = rt;
                isLoad = 1'b1;
            end
            opSw: begin
                useRt = 1'b1;
                isStore = 1'b1;
            end
            opBeq, opBne: begin
                useRt = 1'b1;
                isBranch = 1'b1;
            end
            default: dest = '0;
        endcase
    end

    assign imm = zeroExt ? {16'b0, decInstr[15:0]} : {{16{decInstr[15]}}, decInstr[15:0]};

    always_comb begin
        rsValue = forward(rs, regFile[rs]);
        rtValue = forward(rt, regFile[rt]);
        decodeWait = decValid && (conflicts(rs) || (useRt && conflicts(rt)));
    end

    assign issue = decValid && !decodeWait;

    // BEQ compares equal, BNE not equal
    assign redirect = issue && isBranch && ((rsValue == rtValue) == (opcode == opBeq));
    assign redirectAddr = decPc + 32'd4 + {imm[29:0], 2'b00};

    assign dxAluOp = aluOp;
    assign dxA = rsValue;
    assign dxB = useImm ? imm : rtValue;
    assign dxDest = issue ? dest : '0;
    assign dxLoad = issue && isLoad;
    assign dxStore = issue && isStore;
    assign dxStoreData = rtValue;
    assign dxPc = decPc;

endmodule

// File: rtl/executeStage.sv
module executeStage import cpuPkg::*; (
    input  logic     clk,
    input  logic     reset,
    input  logic     hold,
    input  aluOpE    dxAluOp,
    input  wordT     dxA,
    input  wordT     dxB,
    input  regIndexT dxDest,
    input  logic     dxLoad,
    input  logic     dxStore,
    input  wordT     dxStoreData,
    input  wordT     dxPc,
    output regIndexT exDest,
    output wordT     xmResult,
    output wordT     xmStoreData,
    output wordT     xmPc,
    output regIndexT xmDest,
    output logic     xmLoad,
    output logic     xmStore
);
    aluOpE exAluOp;
    wordT exA;
    wordT exB;

    always_ff @(posedge clk) begin
        if (reset) begin
            exDest <= '0;
            xmLoad <= 1'b0;
            xmStore <= 1'b0;
        end else if (!hold) begin
            exDest <= dxDest;
            xmLoad <= dxLoad;
            xmStore <= dxStore;
        end
    end

    always_ff @(posedge clk) begin
        if (!hold) begin
            exAluOp <= dxAluOp;
            exA <= dxA;
            exB <= dxB;
            xmStoreData <= dxStoreData;
            xmPc <= dxPc;
        end
    end

    always_comb begin
        case (exAluOp)
            aluSub: xmResult = exA - exB;
            aluAnd: xmResult = exA & exB;
            aluOr: xmResult = exA | exB;
            aluSlt: xmResult = {31'b0, $signed(exA) < $signed(exB)};
            aluLui: xmResult = {exB[15:0], 16'b0};
            default: xmResult = exA + exB;
        endcase
    end

    assign xmDest = exDest;

endmodule

// File: rtl/memoryStage.sv
module memoryStage import cpuPkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  wordT       xmResult,
    input  wordT       xmStoreData,
    input  wordT       xmPc,
    input  regIndexT   xmDest,
    input  logic       xmLoad,
    input  logic       xmStore,
    output logic       memWait,
    output regIndexT   memDest,
    output wordT       memValue,
    output logic       memValueValid,
    output logic       dataReq,
    output logic       dataWrite,
    output wordT       dataAddr,
    output wordT       dataWdata,
    input  logic       dataDone,
    input  wordT       rdata,
    output regIndexT   wbDest,
    output wordT       wbValue,
    output wordT       debugWbPc,
    output logic [3:0] debugWbRfWen,
    output regIndexT   debugWbRfWnum,
    output wordT       debugWbRfWdata
);
    logic memLoad;
    logic memStore;
    wordT memPc;

    assign dataReq = memLoad || memStore;
    assign memWait = dataReq && !dataDone;

    always_ff @(posedge clk) begin
        if (reset) begin
            memDest <= '0;
            memLoad <= 1'b0;
            memStore <= 1'b0;
            wbDest <= '0;
        end else if (!memWait) begin
            memDest <= xmDest;
            memLoad <= xmLoad;
            memStore <= xmStore;
            wbDest <= memDest;
        end else begin
            // Write-back sees a bubble while the bus is busy
            wbDest <= '0;
        end
    end

    always_ff @(posedge clk) begin
        if (!memWait) begin
            memValue <= xmResult;
            dataWdata <= xmStoreData;
            memPc <= xmPc;
            wbValue <= memLoad ? rdata : memValue;
            debugWbPc <= memPc;
        end
    end

    // Load data only exists after write-back
    assign memValueValid = !memLoad;
    assign dataWrite = memStore;
    assign dataAddr = memValue;

    assign debugWbRfWen = (wbDest != '0) ? 4'hf : 4'h0;
    assign debugWbRfWnum = wbDest;
    assign debugWbRfWdata = wbValue;

endmodule

// File: rtl/apbArbiter.sv
module apbArbiter import cpuPkg::*, apbPkg::*; (
    input  logic clk,
    input  logic reset,
    input  logic fetchReq,
    input  wordT fetchAddr,
    output logic fetchDone,
    input  logic dataReq,
    input  logic dataWrite,
    input  wordT dataAddr,
    input  wordT dataWdata,
    output logic dataDone,
    output wordT rdata,
    output wordT paddr,
    output logic psel,
    output logic penable,
    output logic pwrite,
    output wordT pwdata,
    input  wordT prdata,
    input  logic pready
);
    apbPhaseE phase;
    requesterE owner;
    logic done;

    assign done = phase == phaseAccess && pready;
    assign fetchDone = done && owner == reqFetch;
    assign dataDone = done && owner == reqData;
    assign rdata = prdata;
    assign psel = phase != phaseIdle;
    assign penable = phase == phaseAccess;

    always_ff @(posedge clk) begin
        if (reset) begin
            phase <= phaseIdle;
            owner <= reqFetch;
            pwrite <= 1'b0;
        end else begin
            case (phase)
                phaseIdle: begin
                    // Data first so the older instruction drains
                    if (dataReq) begin
                        phase <= phaseSetup;
                        owner <= reqData;
                        pwrite <= dataWrite;
                    end else if (fetchReq) begin
                        phase <= phaseSetup;
                        owner <= reqFetch;
                        pwrite <= 1'b0;
                    end
                end
                phaseSetup: phase <= phaseAccess;
                phaseAccess: begin
                    if (pready) begin
                        phase <= phaseIdle;
                    end
                end
                default: phase <= phaseIdle;
            endcase
        end
    end

    // Fields latched at grant and kept until completion
    always_ff @(posedge clk) begin
        if (phase == phaseIdle) begin
            paddr <= dataReq ? dataAddr : fetchAddr;
            pwdata <= dataWdata;
        end
    end

endmodule

// File: rtl/pipelineCpu.sv
module pipelineCpu import cpuPkg::*; #(
    parameter wordT resetVector = '0
) (
    input  logic       clk,
    input  logic       reset,
    output wordT       paddr,
    output logic       psel,
    output logic       penable,
    output logic       pwrite,
    output wordT       pwdata,
    input  wordT       prdata,
    input  logic       pready,
    output wordT       debugWbPc,
    output logic [3:0] debugWbRfWen,
    output regIndexT   debugWbRfWnum,
    output wordT       debugWbRfWdata
);
    stallLevelE stallLevel;
    logic frontHold, executeHold;
    logic decodeWait, memWait, redirect, instrValid, fetchReq, fetchDone;
    logic dataReq, dataWrite, dataDone, dxLoad, dxStore, xmLoad, xmStore, memValueValid;
    wordT redirectAddr, fetchAddr, instr, instrPc, rdata, dataAddr, dataWdata;
    wordT dxA, dxB, dxStoreData, dxPc, xmResult, xmStoreData, xmPc, memValue, wbValue;
    regIndexT dxDest, exDest, xmDest, memDest, wbDest;
    aluOpE dxAluOp;

    always_comb begin
        stallLevel = stallNone;
        if (decodeWait) begin
            stallLevel = stallDecode;
        end
        if (memWait) begin
            stallLevel = stallMemory;
        end
    end

    // Fetch freezes together with decode
    assign frontHold = stallLevel >= stallDecode;
    assign executeHold = stallLevel >= stallExecute;

    fetchUnit #(.resetVector(resetVector)) fetch (
        .clk, .reset, .hold(frontHold), .redirect, .redirectAddr, .fetchReq, .fetchAddr,
        .fetchDone, .rdata, .instr, .instrPc, .instrValid
    );

    decodeStage decode (
        .clk, .reset, .hold(frontHold), .instr, .instrPc, .instrValid, .exDest, .memDest,
        .memValue, .memValueValid, .wbDest, .wbValue, .decodeWait, .redirect, .redirectAddr,
        .dxAluOp, .dxA, .dxB, .dxDest, .dxLoad, .dxStore, .dxStoreData, .dxPc
    );

    executeStage execute (
        .clk, .reset, .hold(executeHold), .dxAluOp, .dxA, .dxB, .dxDest, .dxLoad, .dxStore,
        .dxStoreData, .dxPc, .exDest, .xmResult, .xmStoreData, .xmPc, .xmDest, .xmLoad, .xmStore
    );

    memoryStage memory (
        .clk, .reset, .xmResult, .xmStoreData, .xmPc, .xmDest, .xmLoad, .xmStore, .memWait,
        .memDest, .memValue, .memValueValid, .dataReq, .dataWrite, .dataAddr, .dataWdata,
        .dataDone, .rdata, .wbDest, .wbValue, .debugWbPc, .debugWbRfWen, .debugWbRfWnum,
        .debugWbRfWdata
    );

    apbArbiter arbiter (
        .clk, .reset, .fetchReq, .fetchAddr, .fetchDone, .dataReq, .dataWrite, .dataAddr,
        .dataWdata, .dataDone, .rdata, .paddr, .psel, .penable, .pwrite, .pwdata, .prdata, .pready
    );

endmodule

// File: testbench/apbArbiter_checker.sv
module apbArbiterChecker import cpuPkg::*; (
    input logic clk,
    input logic reset,
    input logic psel,
    input logic penable,
    input logic pready,
    input logic pwrite,
    input wordT paddr,
    input wordT pwdata,
    input logic fetchReq,
    input logic dataReq,
    input logic dataWrite,
    input logic fetchDone,
    input logic dataDone
);
    // Access phase only after a setup cycle
    assert property (@(posedge clk) disable iff (reset)
        (penable && !$past(penable)) |-> $past(psel && !penable))
        else $error("penable raised without setup cycle");

    assert property (@(posedge clk) disable iff (reset)
        (psel && !(penable && pready)) |=> ($stable(paddr) && $stable(pwrite) && $stable(pwdata)))
        else $error("APB fields changed during transfer");

    // One done per completed transfer, to the side that asked for it
    assert property (@(posedge clk) disable iff (reset)
        (psel && penable && pready) |->
            ((fetchDone && !dataDone && fetchReq && !pwrite)
             || (dataDone && !fetchDone && dataReq && pwrite == dataWrite)))
        else $error("done pulse not routed to the requester of the transfer");

endmodule

bind apbArbiter apbArbiterChecker protocolCheck (
    .clk, .reset, .psel, .penable, .pready, .pwrite, .paddr, .pwdata, .fetchReq, .dataReq,
    .dataWrite, .fetchDone, .dataDone
);

// File: testbench/pipelineCpuTb.sv
module pipelineCpuTb;
    import cpuPkg::*;

    localparam int maxProgLen = 12;
    localparam int numTests = 4;
    localparam int ramWords = 1024;
    localparam logic [31:0] selfLoop = 32'h1000ffff;
    localparam wordT resetAddr = 32'h0000_0100;

    logic clk;
    logic reset;
    logic [31:0] prdata;
    logic pready;
    wordT paddr;
    logic psel;
    logic penable;
    logic pwrite;
    wordT pwdata;
    wordT debugWbPc;
    logic [3:0] debugWbRfWen;
    regIndexT debugWbRfWnum;
    wordT debugWbRfWdata;

    logic [31:0] ram [ramWords];
    logic [31:0] goldMem [ramWords];
    logic [31:0] prog [$];
    logic [31:0] expPc [$];
    logic [31:0] expNum [$];
    logic [31:0] expVal [$];
    logic [31:0] gotPc [$];
    logic [31:0] gotNum [$];
    logic [31:0] gotVal [$];
    logic [31:0] rngState;
    int waitLeft;
    int errors;

    pipelineCpu #(.resetVector(resetAddr)) uut (
        .clk, .reset, .paddr, .psel, .penable, .pwrite, .pwdata, .prdata, .pready,
        .debugWbPc, .debugWbRfWen, .debugWbRfWnum, .debugWbRfWdata
    );

    always #2 clk = ~clk;

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        s ^= s << 13;
        s ^= s >> 17;
        s ^= s << 5;
        return s;
    endfunction

    function automatic logic [31:0] encodeR(int rs, int rt, int rd, logic [5:0] funct);
        return {6'h00, rs[4:0], rt[4:0], rd[4:0], 5'd0, funct};
    endfunction

    function automatic logic [31:0] encodeI(logic [5:0] op, int rs, int rt, int imm);
        return {op, rs[4:0], rt[4:0], imm[15:0]};
    endfunction

    // APB slave with 0 to 3 wait states
    always @(negedge clk) begin
        if (reset || !psel) begin
            pready <= 1'b0;
        end else if (!penable) begin
            rngState = xorshift(rngState);
            waitLeft = rngState % 4;
            pready <= 1'b0;
        end else if (!pready) begin
            if (waitLeft == 0) begin
                pready <= 1'b1;
                if (pwrite) begin
                    ram[paddr[11:2]] = pwdata;
                end else begin
                    prdata <= ram[paddr[11:2]];
                end
            end else begin
                waitLeft--;
            end
        end else begin
            pready <= 1'b0;
        end
    end

    // Write-back trace
    always @(negedge clk) begin
        if (!reset && debugWbRfWen != 4'h0) begin
            if (debugWbRfWen != 4'hf) begin
                errors++;
                $display("FAILED at %0t: write enable %h is not all ones", $time, debugWbRfWen);
            end
            gotPc.push_back(debugWbPc);
            gotNum.push_back(debugWbRfWnum);
            gotVal.push_back(debugWbRfWdata);
        end
    end

    // ISA reference with one delay slot
    task automatic runGolden();
        logic [31:0] regs [32];
        logic [31:0] pc, npc, newNpc, ins, a, b, val, simm;
        int dest;
        int steps;
        foreach (regs[i]) regs[i] = '0;
        pc = resetAddr;
        npc = resetAddr + 4;
        for (steps = 0; steps < 200; steps++) begin
            ins = goldMem[pc[11:2]];
            if (ins == selfLoop) break;
            a = regs[ins[25:21]];
            b = regs[ins[20:16]];
            simm = {{16{ins[15]}}, ins[15:0]};
            newNpc = npc + 4;
            dest = ins[20:16];
            val = '0;
            case (ins[31:26])
                6'h00: begin
                    dest = ins[15:11];
                    case (ins[5:0])
                        6'h21: val = a + b;
                        6'h23: val = a - b;
                        6'h24: val = a & b;
                        6'h25: val = a | b;
                        6'h2a: val = {31'b0, $signed(a) < $signed(b)};
                        default: dest = 0;
                    endcase
                end
                6'h09: val = a + simm;
                6'h0d: val = a | {16'b0, ins[15:0]};
                6'h0f: val = {ins[15:0], 16'b0};
                6'h23: val = goldMem[(a + simm) >> 2];
                6'h2b: begin
                    goldMem[(a + simm) >> 2] = b;
                    dest = 0;
                end
                6'h04, 6'h05: begin
                    if ((a == b) == (ins[31:26] == 6'h04)) begin
                        newNpc = pc + 4 + (simm << 2);
                    end
                    dest = 0;
                end
                default: dest = 0;
            endcase
            if (dest != 0) begin
                regs[dest] = val;
                expPc.push_back(pc);
                expNum.push_back(dest);
                expVal.push_back(val);
            end
            pc = npc;
            npc = newNpc;
        end
    endtask

    task automatic resetAndCheckFirstFetch();
        int cycles;
        @(negedge clk);
        reset = 1'b1;
        repeat (8) begin
            @(negedge clk);
            if (psel || debugWbRfWen != 4'h0) begin
                errors++;
                $display("FAILED at %0t: bus or write-back active during reset", $time);
            end
        end
        reset = 1'b0;
        gotPc.delete();
        gotNum.delete();
        gotVal.delete();
        cycles = 0;
        while (!psel && cycles < 20) begin
            if (debugWbRfWen != 4'h0) begin
                errors++;
                $display("FAILED at %0t: write-back before first fetch", $time);
            end
            @(negedge clk);
            cycles++;
        end
        if (!psel) begin
            errors++;
            $display("No fetch was started after reset");
        end else if (paddr != resetAddr || pwrite) begin
            errors++;
            $display("FAILED at %0t: first fetch addr %h write %b", $time, paddr, pwrite);
        end
    endtask

    task automatic runProgram(input string name);
        int cycles;
        int limit;
        for (int i = 0; i < ramWords; i++) begin
            ram[i] = (i * 4) * 32'h9e3779b1 ^ 32'h5a5a1234;
        end
        foreach (prog[i]) ram[resetAddr[11:2] + i] = prog[i];
        goldMem = ram;
        expPc.delete();
        expNum.delete();
        expVal.delete();
        runGolden();
        resetAndCheckFirstFetch();
        limit = 200 * prog.size();
        cycles = 0;
        while (gotPc.size() < expPc.size() && cycles < limit) begin
            @(negedge clk);
            cycles++;
        end
        repeat (40) @(negedge clk);
        foreach (expPc[i]) begin
            if (i >= gotPc.size()) begin
                errors++;
                $display("%s: write-back entry %0d never appeared", name, i);
            end else if (gotPc[i] != expPc[i] || gotNum[i] != expNum[i]
                         || gotVal[i] != expVal[i]) begin
                errors++;
                $display("FAILED at %0t: %s entry %0d got pc %h r%0d=%h, expected pc %h r%0d=%h",
                         $time, name, i, gotPc[i], gotNum[i], gotVal[i],
                         expPc[i], expNum[i], expVal[i]);
            end
        end
        if (gotPc.size() > expPc.size()) begin
            errors++;
            $display("%s: %0d extra write-back entries", name, gotPc.size() - expPc.size());
        end
        for (int i = 0; i < ramWords; i++) begin
            if (ram[i] != goldMem[i]) begin
                errors++;
                $display("FAILED at %0t: %s memory word %0d is %h, expected %h",
                         $time, name, i, ram[i], goldMem[i]);
            end
        end
        prog.delete();
    endtask

    task automatic aluChainTest();
        prog = '{encodeI(6'h0d, 0, 1, 16'h1234), encodeI(6'h0f, 0, 2, 16'h8000),
                 encodeR(1, 2, 3, 6'h21), encodeR(3, 1, 4, 6'h23), encodeR(3, 1, 5, 6'h24),
                 encodeR(4, 5, 6, 6'h25), encodeR(2, 1, 7, 6'h2a), encodeI(6'h09, 7, 8, -3),
                 encodeR(1, 8, 9, 6'h2a), selfLoop, 32'h0};
        runProgram("aluChain");
    endtask

    task automatic loadStoreTest();
        prog = '{encodeI(6'h09, 0, 1, 16'h0200), encodeI(6'h0d, 0, 2, 16'hbeef),
                 encodeI(6'h2b, 1, 2, 4), encodeI(6'h23, 1, 3, 4), encodeR(3, 3, 4, 6'h21),
                 encodeI(6'h23, 1, 5, 8), encodeR(5, 4, 6, 6'h21), encodeI(6'h2b, 1, 6, 12),
                 selfLoop, 32'h0};
        runProgram("loadStore");
    endtask

    task automatic branchTest();
        // Not-taken BEQ, then taken BNE skipping one word
        prog = '{encodeI(6'h09, 0, 1, 1), encodeI(6'h04, 1, 0, 2), encodeI(6'h09, 0, 2, 2),
                 encodeI(6'h09, 0, 3, 3), encodeI(6'h05, 1, 0, 2), encodeI(6'h09, 0, 4, 4),
                 encodeI(6'h09, 0, 5, 5), encodeI(6'h09, 0, 6, 6), selfLoop, 32'h0};
        runProgram("branch");
    endtask

    task automatic zeroRegTest();
        prog = '{encodeI(6'h09, 0, 0, 7), encodeR(0, 0, 1, 6'h21), encodeI(6'h0d, 0, 2, 9),
                 encodeR(0, 2, 3, 6'h25), selfLoop, 32'h0};
        runProgram("zeroReg");
    endtask

    initial begin
        repeat (200 * maxProgLen * numTests) @(posedge clk);
        $display("Watchdog expired before the tests finished");
        $display("Simulation failed");
        $finish;
    end

    initial begin
        clk = 1'b0;
        reset = 1'b1;
        prdata = '0;
        pready = 1'b0;
        rngState = 32'h35de;
        errors = 0;
        aluChainTest();
        loadStoreTest();
        branchTest();
        zeroRegTest();
        $display("Tests done with %0d errors", errors);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// File: pipelineCpu.f
rtl/cpuPkg.sv
rtl/apbPkg.sv
rtl/fetchUnit.sv
rtl/decodeStage.sv
rtl/executeStage.sv
rtl/memoryStage.sv
rtl/apbArbiter.sv
rtl/pipelineCpu.sv
testbench/apbArbiter_checker.sv
testbench/pipelineCpuTb.sv

// File: runSim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal -f pipelineCpu.f --top-module pipelineCpuTb
./obj_dir/VpipelineCpuTb > sim.log 2>&1 || true
cat sim.log
if grep -q "Simulation failed" sim.log; then
    exit 1
fi
grep -q "Simulation completed successfully" sim.log
